//--- bin_to_bcd.sv
`timescale 1ns/1ns

module bin_to_bcd (
  input  game_pkg::score_t                                 binary,
  output game_pkg::bcd_digit_t [game_pkg::SCORE_DIGITS-1:0] digits
);
  import game_pkg::*;

  localparam int BIN_W = $bits(score_t);
  // one spare digit so a 16 bit value never overflows
  localparam int BCD_W = 4 * (SCORE_DIGITS + 1);

  ////////////////////////////////////////
  // double dabble, one stage per bit
  ////////////////////////////////////////
  always_comb begin
    logic [BCD_W-1:0] bcd;
    bcd = '0;
    for (int i = BIN_W - 1; i >= 0; i--) begin
      // add 3 to any digit that would pass 9 after the shift
      for (int d = 0; d < BCD_W / 4; d++) begin
        if (bcd[4*d +: 4] >= 4'd5) begin
          bcd[4*d +: 4] = bcd[4*d +: 4] + 4'd3;
        end
      end
      bcd = {bcd[BCD_W-2:0], binary[i]};
    end
    // keep the low digits, ones first
    for (int d = 0; d < SCORE_DIGITS; d++) begin
      digits[d] = bcd[4*d +: 4];
    end
  end

endmodule : bin_to_bcd

//--- font_rom.sv
`timescale 1ns/1ns

module font_rom (
  glyph_if.rom glyph
);
  import video_pkg::*;

  // one byte per glyph row, row 0 in the low byte
  // bit 0 of each byte is the leftmost pixel
  logic [CHAR_WIDTH*CHAR_HEIGHT-1:0] bitmap;

  always_comb begin
    case (glyph.char_code)
      " ": bitmap = 64'h0000000000000000;
      // digits
      "0": bitmap = 64'h003E676F7B73633E;
      "1": bitmap = 64'h003F0C0C0C0C0E0C;
      "2": bitmap = 64'h003F33061C30331E;
      "3": bitmap = 64'h001E33301C30331E;
      "4": bitmap = 64'h0078307F33363C38;
      "5": bitmap = 64'h001E3330301F033F;
      "6": bitmap = 64'h001E33331F03061C;
      "7": bitmap = 64'h000C0C0C1830333F;
      "8": bitmap = 64'h001E33331E33331E;
      "9": bitmap = 64'h000E18303E33331E;
      // punctuation
      "!": bitmap = 64'h00180018183C3C18;
      "(": bitmap = 64'h00180C0606060C18;
      ".": bitmap = 64'h000C0C0000000000;
      ":": bitmap = 64'h000C0C00000C0C00;
      // letters in the strings
      "A": bitmap = 64'h0033333F33331E0C;
      "C": bitmap = 64'h003C66030303663C;
      "D": bitmap = 64'h001F36666666361F;
      "E": bitmap = 64'h007F46161E16467F;
      "G": bitmap = 64'h007C66730303663C;
      "H": bitmap = 64'h003333333F333333;
      "I": bitmap = 64'h001E0C0C0C0C0C1E;
      "K": bitmap = 64'h006766361E366667;
      "L": bitmap = 64'h007F66460606060F;
      "N": bitmap = 64'h006363737B6F6763;
      "O": bitmap = 64'h001C36636363361C;
      "P": bitmap = 64'h000F06063E66663F;
      "R": bitmap = 64'h006766363E66663F;
      "S": bitmap = 64'h001E33380E07331E;
      "T": bitmap = 64'h001E0C0C0C0C2D3F;
      "U": bitmap = 64'h003F333333333333;
      "Y": bitmap = 64'h001E0C0C1E333333;
      // unknown codes draw nothing
      default: bitmap = '0;
    endcase
  end

  // row selects the byte, column the bit
  assign glyph.pixel = bitmap[{glyph.glyph_row, glyph.glyph_col}];

endmodule : font_rom

//--- game_pkg.sv
package game_pkg;

  // game state as set by the host
  typedef enum logic [1:0] {
    GAME_MODE_LOADING = 2'd0,
    GAME_MODE_READY   = 2'd1,
    GAME_MODE_PLAY    = 2'd2,
    GAME_MODE_FAIL    = 2'd3
  } game_mode_t;

  // score, binary and decimal
  typedef logic [15:0] score_t;
  typedef logic [3:0] bcd_digit_t;
  localparam int SCORE_DIGITS = 4;

  // apb register map, byte addresses
  typedef logic [3:0] reg_addr_t;
  localparam reg_addr_t REG_MODE = 4'h0;
  localparam reg_addr_t REG_SCORE = 4'h4;

endpackage : game_pkg

//--- game_regs.sv
`timescale 1ns/1ns

module game_regs (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  game_pkg::reg_addr_t  paddr,
  input  logic [31:0]          pwdata,
  output logic [31:0]          prdata,
  output logic                 pready,
  output logic                 pslverr,
  output game_pkg::game_mode_t mode,
  output game_pkg::score_t     score
);
  import game_pkg::*;

  logic        setup_phase;
  logic        access_phase;
  logic        addr_ok;
  logic [31:0] rd_value;

  // apb phase decode
  assign setup_phase = psel && !penable;
  assign access_phase = psel && penable;
  assign addr_ok = (paddr == REG_MODE) || (paddr == REG_SCORE);

  // no wait states
  assign pready = 1'b1;

  // read mux, zero extended
  always_comb begin
    case (paddr)
      REG_MODE:  rd_value = {30'd0, mode};
      REG_SCORE: rd_value = {16'd0, score};
      default:   rd_value = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mode <= GAME_MODE_LOADING;
      score <= '0;
      prdata <= '0;
      pslverr <= 1'b0;
    end else begin
      // error and read data set up so they sit on the bus during access
      pslverr <= setup_phase && !addr_ok;
      if (setup_phase && !pwrite) begin
        prdata <= rd_value;
      end
      // writes land at the end of the access phase
      if (access_phase && pwrite) begin
        case (paddr)
          REG_MODE:  mode <= game_mode_t'(pwdata[1:0]);
          REG_SCORE: score <= pwdata[15:0];
          default:   ;
        endcase
      end
    end
  end

endmodule : game_regs

//--- glyph_if.sv
`timescale 1ns/1ns

interface glyph_if;
  import video_pkg::*;

  // lookup request from the overlay
  char_code_t char_code;
  glyph_idx_t glyph_row;
  glyph_idx_t glyph_col;
  // bitmap bit back from the rom
  logic pixel;

  modport overlay (output char_code, glyph_row, glyph_col, input pixel);
  modport rom (input char_code, glyph_row, glyph_col, output pixel);
endinterface : glyph_if

//--- overlay_testdata.txt
# mode score sx sy flash expected, all hex
# mode 0 loading 1 ready 2 play 3 fail, flash is the blink phase to wait for
0 0000 68 088 0 f
0 0000 6c 088 0 0
0 0000 72 088 1 f
1 0000 68 088 0 f
1 0000 68 088 1 0
1 0000 71 08b 0 f
1 0000 20 010 1 f
1 0000 20 010 0 0
1 0000 38 012 1 f
1 0000 75 010 1 f
1 0000 73 010 1 0
2 04d2 2a 008 0 f
2 04d2 28 008 0 0
2 04d2 43 008 1 f
2 04d2 40 00c 0 f
2 0000 29 008 0 f
2 0000 28 009 1 f
2 270f 44 00c 0 f
2 270f 40 00c 0 0
2 3039 29 008 0 f
2 04d2 58 000 0 f
2 04d2 5a 000 0 0
2 04d2 68 088 0 0
3 04d2 68 088 0 f
3 04d2 bb 088 1 f
3 04d2 b2 089 0 f
3 04d2 20 010 0 f
3 04d2 20 010 1 0
3 04d2 58 000 1 f
0 0000 00 12c 0 0
1 0000 ff 1ff 1 0
3 04d2 ff 1ff 0 0

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_text_overlay -f verilog.f -o sim_text_overlay

out=$(./obj_dir/sim_text_overlay 2>&1) || { echo "$out"; exit 1; }
echo "$out"

if echo "$out" | grep -q "^ALL CHECKS PASSED$"; then
  exit 0
else
  exit 1
fi

//--- strobe_gen.sv
`timescale 1ns/1ns

module strobe_gen #(
  parameter int unsigned FLASH_CYCLES = 25_000_000
) (
  input  logic clk,
  input  logic reset,
  output logic flash
);

  // wide enough for FLASH_CYCLES - 1
  localparam int CNT_W = (FLASH_CYCLES > 1) ? $clog2(FLASH_CYCLES) : 1;

  logic [CNT_W-1:0] cnt;

  // phase flips each time the counter wraps
  always_ff @(posedge clk) begin
    if (reset) begin
      cnt <= '0;
      flash <= 1'b0;
    end else if (cnt == CNT_W'(FLASH_CYCLES - 1)) begin
      cnt <= '0;
      flash <= !flash;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule : strobe_gen

//--- tb_text_overlay.sv
`timescale 1ns/1ns

module tb_text_overlay;
  import game_pkg::*;
  import video_pkg::*;

  localparam int unsigned FLASH_CYCLES = 1024;
  localparam int CLK_PERIOD = 20;
  localparam int APB_TIMEOUT = 16;
  localparam int PHASE_TIMEOUT = 4 * FLASH_CYCLES;
  // clocks a pixel check needs inside one blink phase, with slack
  localparam int PHASE_MARGIN = 8;
  localparam reg_addr_t BAD_ADDR = 4'h8;

  logic        clk;
  logic        reset;
  logic        psel;
  logic        penable;
  logic        pwrite;
  reg_addr_t   paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  coord_x_t    sx;
  coord_y_t    sy;
  color_t      r;
  color_t      g;
  color_t      b;

  // clocks since reset release, same count the blink timer sees
  int unsigned clk_count;

  text_overlay_top #(
    .FLASH_CYCLES (FLASH_CYCLES)
  ) i_text_overlay_top (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .sx      (sx),
    .sy      (sy),
    .r       (r),
    .g       (g),
    .b       (b)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    if (reset) begin
      clk_count <= 0;
    end else begin
      clk_count <= clk_count + 1;
    end
  end

  ////////////////////////////////////////
  // error stop and compare tasks
  ////////////////////////////////////////
  task automatic stop_with_error(string what);
    $display("%s", what);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_color(string name, color_t got, color_t exp);
    if (got !== exp) begin
      stop_with_error($sformatf("FAILED %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_rdata(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      stop_with_error($sformatf("FAILED %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_slverr(logic got, logic exp);
    if (got !== exp) begin
      stop_with_error($sformatf("FAILED pslverr got %h expected %h", got, exp));
    end
  endtask

  ////////////////////////////////////////
  // apb master, entered and left on a falling edge
  ////////////////////////////////////////
  task automatic apb_transfer(input logic write, input reg_addr_t addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    int waited;
    waited = 0;
    // setup phase
    psel = 1'b1;
    penable = 1'b0;
    pwrite = write;
    paddr = addr;
    pwdata = wdata;
    @(negedge clk);
    penable = 1'b1;
    // sample mid access phase, away from both edges
    #(CLK_PERIOD / 4);
    while (pready !== 1'b1) begin
      if (waited >= APB_TIMEOUT) begin
        stop_with_error("apb access timed out waiting for pready");
      end else begin
        @(negedge clk);
        #(CLK_PERIOD / 4);
        waited++;
      end
    end
    rdata = prdata;
    err = pslverr;
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apb_write(reg_addr_t addr, logic [31:0] data, logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_transfer(1'b1, addr, data, rdata, err);
    check_slverr(err, exp_err);
  endtask

  task automatic apb_read(reg_addr_t addr, logic [31:0] exp_data, logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_transfer(1'b0, addr, 32'd0, rdata, err);
    check_slverr(err, exp_err);
    if (!exp_err) begin
      check_rdata($sformatf("prdata at %h", addr), rdata, exp_data);
    end
  endtask

  ////////////////////////////////////////
  // blink phase and pixel checks
  ////////////////////////////////////////
  // low for the first FLASH_CYCLES clocks, then toggles
  function automatic logic phase_ready(logic phase);
    return (((clk_count / FLASH_CYCLES) % 2) == phase) &&
           ((clk_count % FLASH_CYCLES) < FLASH_CYCLES - PHASE_MARGIN);
  endfunction

  task automatic wait_for_phase(logic phase);
    int waited;
    waited = 0;
    while (!phase_ready(phase)) begin
      if (waited >= PHASE_TIMEOUT) begin
        stop_with_error("blink phase never reached");
      end else begin
        @(negedge clk);
        waited++;
      end
    end
  endtask

  task automatic check_pixel(coord_x_t x, coord_y_t y, color_t exp);
    string at;
    at = $sformatf("at sx=%h sy=%h", x, y);
    sx = x;
    sy = y;
    @(negedge clk);
    check_color({"r ", at}, r, exp);
    check_color({"g ", at}, g, exp);
    check_color({"b ", at}, b, exp);
    // blank cell next, result must hold until the clock
    sx = '0;
    sy = 9'h1ff;
    #(CLK_PERIOD / 4);
    check_color({"r held ", at}, r, exp);
    check_color({"g held ", at}, g, exp);
    check_color({"b held ", at}, b, exp);
    // a late result would show here
    @(negedge clk);
    check_color("r after blank cell", r, 4'h0);
    check_color("g after blank cell", g, 4'h0);
    check_color("b after blank cell", b, 4'h0);
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////
  initial begin
    int          fd;
    int          n;
    int          vectors;
    string       line;
    logic [31:0] mode_v;
    logic [31:0] score_v;
    logic [31:0] x_v;
    logic [31:0] y_v;
    logic [31:0] phase_v;
    logic [31:0] exp_v;
    reset = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    sx = '0;
    sy = '0;
    vectors = 0;
    // four rising edges in reset, release on the next falling edge
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // reset values, then 'L' of LOADING... row 0 col 0
    apb_read(REG_MODE, 32'd0, 1'b0);
    apb_read(REG_SCORE, 32'd0, 1'b0);
    check_pixel(8'd104, 9'd136, 4'hf);

    // readback and a bad address
    apb_write(REG_MODE, 32'd2, 1'b0);
    apb_write(REG_SCORE, 32'h0000_1234, 1'b0);
    apb_read(REG_MODE, 32'd2, 1'b0);
    apb_read(REG_SCORE, 32'h0000_1234, 1'b0);
    apb_write(BAD_ADDR, 32'hffff_ffff, 1'b1);
    apb_read(BAD_ADDR, 32'd0, 1'b1);
    apb_read(REG_MODE, 32'd2, 1'b0);
    apb_read(REG_SCORE, 32'h0000_1234, 1'b0);

    // pixel vectors from the data file
    fd = $fopen("overlay_testdata.txt", "r");
    if (fd == 0) begin
      stop_with_error("cannot open overlay_testdata.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 0 && line[0] != "#") begin
        n = $sscanf(line, "%h %h %h %h %h %h", mode_v, score_v, x_v, y_v, phase_v, exp_v);
        if (n == 6) begin
          apb_write(REG_MODE, {30'd0, mode_v[1:0]}, 1'b0);
          apb_write(REG_SCORE, {16'd0, score_v[15:0]}, 1'b0);
          wait_for_phase(phase_v[0]);
          check_pixel(coord_x_t'(x_v), coord_y_t'(y_v), color_t'(exp_v));
          vectors++;
        end
      end
    end
    $fclose(fd);
    if (vectors == 0) begin
      stop_with_error("no vectors read from overlay_testdata.txt");
    end

    if (i_text_overlay_top.i_text_overlay_props.fail_count == 0) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      $display("CHECKS FAILED");
      $fatal(1, "assertion failures during the run");
    end
  end

endmodule : tb_text_overlay

//--- text_overlay.sv
`timescale 1ns/1ns

module text_overlay (
  input  logic                                             clk,
  input  logic                                             reset,
  input  game_pkg::game_mode_t                             mode,
  input  video_pkg::coord_x_t                              sx,
  input  video_pkg::coord_y_t                              sy,
  input  logic                                             flash,
  input  game_pkg::bcd_digit_t [game_pkg::SCORE_DIGITS-1:0] digits,
  glyph_if.overlay                                         glyph,
  output video_pkg::color_t                                r,
  output video_pkg::color_t                                g,
  output video_pkg::color_t                                b
);
  import game_pkg::*;
  import video_pkg::*;

  ////////////////////////////////////////
  // strings and start cells
  ////////////////////////////////////////
  localparam logic [8*10-1:0] TXT_LOADING = "LOADING...";
  localparam logic [8*6-1:0] TXT_READY = "READY!";
  localparam logic [8*11-1:0] TXT_LOST = "YOU LOST :(";
  localparam logic [8*23-1:0] TXT_PRESS = "PRESS ANY KEY TO START!";
  localparam logic [8*25-1:0] TXT_RESET = "PRESS RESET TO PLAY AGAIN";
  localparam logic [8*10-1:0] TXT_HIGH = "HIGH SCORE";
  // longest string sets the function argument width
  localparam int MAX_LEN = $bits(TXT_RESET) / 8;

  // centre text, loading, ready and lost share it
  localparam int CENTER_X = 13;
  localparam int CENTER_Y = 17;
  // blinking prompts
  localparam int PROMPT_X = 4;
  localparam int PROMPT_Y = 2;
  localparam int HIGH_X = 11;
  localparam int HIGH_Y = 0;
  localparam int SCORE_X = 5;
  localparam int SCORE_Y = 1;

  int         cell_x;
  int         cell_y;
  char_code_t next_char;
  char_code_t char_q;
  glyph_idx_t row_q;
  glyph_idx_t col_q;

  // true when the cell lies inside a string of len chars
  function automatic logic hit(int cx, int cy, int x0, int y0, int len);
    return (cy == y0) && (cx >= x0) && (cx < x0 + len);
  endfunction

  // idx counts from the left, first char sits in the top byte
  function automatic char_code_t text_char(logic [8*MAX_LEN-1:0] txt, int len, int idx);
    return txt[8*(len - 1 - idx) +: 8];
  endfunction

  assign cell_x = int'(sx / CHAR_WIDTH);
  assign cell_y = int'(sy / CHAR_HEIGHT);

  ////////////////////////////////////////
  // character select per mode
  ////////////////////////////////////////
  always_comb begin
    next_char = " ";
    case (mode)
      GAME_MODE_LOADING: begin
        if (hit(cell_x, cell_y, CENTER_X, CENTER_Y, $bits(TXT_LOADING) / 8)) begin
          next_char = text_char(TXT_LOADING, $bits(TXT_LOADING) / 8, cell_x - CENTER_X);
        end
      end
      GAME_MODE_READY: begin
        // ready and the key prompt alternate
        if (!flash && hit(cell_x, cell_y, CENTER_X, CENTER_Y, $bits(TXT_READY) / 8)) begin
          next_char = text_char(TXT_READY, $bits(TXT_READY) / 8, cell_x - CENTER_X);
        end
        if (flash && hit(cell_x, cell_y, PROMPT_X, PROMPT_Y, $bits(TXT_PRESS) / 8)) begin
          next_char = text_char(TXT_PRESS, $bits(TXT_PRESS) / 8, cell_x - PROMPT_X);
        end
      end
      GAME_MODE_PLAY, GAME_MODE_FAIL: begin
        if (hit(cell_x, cell_y, HIGH_X, HIGH_Y, $bits(TXT_HIGH) / 8)) begin
          next_char = text_char(TXT_HIGH, $bits(TXT_HIGH) / 8, cell_x - HIGH_X);
        end
        // thousands digit on the left
        if (hit(cell_x, cell_y, SCORE_X, SCORE_Y, SCORE_DIGITS)) begin
          next_char = 8'h30 + {4'd0, digits[SCORE_DIGITS - 1 - (cell_x - SCORE_X)]};
        end
        if (mode == GAME_MODE_FAIL) begin
          if (hit(cell_x, cell_y, CENTER_X, CENTER_Y, $bits(TXT_LOST) / 8)) begin
            next_char = text_char(TXT_LOST, $bits(TXT_LOST) / 8, cell_x - CENTER_X);
          end
          // reset prompt only in the low phase
          if (!flash && hit(cell_x, cell_y, PROMPT_X, PROMPT_Y, $bits(TXT_RESET) / 8)) begin
            next_char = text_char(TXT_RESET, $bits(TXT_RESET) / 8, cell_x - PROMPT_X);
          end
        end
      end
      default: next_char = " ";
    endcase
  end

  // one pipeline stage, code and glyph position move together
  always_ff @(posedge clk) begin
    if (reset) begin
      char_q <= " ";
      row_q <= '0;
      col_q <= '0;
    end else begin
      char_q <= next_char;
      row_q <= glyph_idx_t'(sy % CHAR_HEIGHT);
      col_q <= glyph_idx_t'(sx % CHAR_WIDTH);
    end
  end

  assign glyph.char_code = char_q;
  assign glyph.glyph_row = row_q;
  assign glyph.glyph_col = col_q;

  // font bit to full white or black
  assign r = {$bits(color_t){glyph.pixel}};
  assign g = {$bits(color_t){glyph.pixel}};
  assign b = {$bits(color_t){glyph.pixel}};

endmodule : text_overlay

//--- text_overlay_props.sv
`timescale 1ns/1ns

module text_overlay_props (
  input logic               clk,
  input logic               reset,
  input logic               psel,
  input logic               penable,
  input logic               pready,
  input logic               pslverr,
  input video_pkg::color_t  r,
  input video_pkg::color_t  g,
  input video_pkg::color_t  b
);

  // failed assertions, read back at the end of the run
  int unsigned fail_count = 0;

  // slave never inserts wait states
  a_pready_high : assert property (@(posedge clk) disable iff (reset) pready)
    else begin
      fail_count++;
      $error("pready dropped low");
    end

  // error only while the access phase is on the bus
  a_slverr_in_access : assert property (
    @(posedge clk) disable iff (reset) pslverr |-> (psel && penable))
    else begin
      fail_count++;
      $error("pslverr outside an access phase");
    end

  // grey output, all channels equal
  a_grey_level : assert property (
    @(posedge clk) disable iff (reset) (r == g) && (g == b))
    else begin
      fail_count++;
      $error("r, g and b differ");
    end

endmodule : text_overlay_props

bind text_overlay_top text_overlay_props i_text_overlay_props (
  .clk     (clk),
  .reset   (reset),
  .psel    (psel),
  .penable (penable),
  .pready  (pready),
  .pslverr (pslverr),
  .r       (r),
  .g       (g),
  .b       (b)
);

//--- text_overlay_top.sv
`timescale 1ns/1ns

module text_overlay_top #(
  parameter int unsigned FLASH_CYCLES = 25_000_000
) (
  input  logic                clk,
  input  logic                reset,
  // apb slave
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  game_pkg::reg_addr_t paddr,
  input  logic [31:0]         pwdata,
  output logic [31:0]         prdata,
  output logic                pready,
  output logic                pslverr,
  // pixel position in, grey level out one clock later
  input  video_pkg::coord_x_t sx,
  input  video_pkg::coord_y_t sy,
  output video_pkg::color_t   r,
  output video_pkg::color_t   g,
  output video_pkg::color_t   b
);
  import game_pkg::*;

  game_mode_t                     mode;
  score_t                         score;
  bcd_digit_t [SCORE_DIGITS-1:0] digits;
  logic                           flash;

  glyph_if glyph_bus ();

  ////////////////////////////////////////
  // host registers and helpers
  ////////////////////////////////////////
  game_regs i_game_regs (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .mode    (mode),
    .score   (score)
  );

  strobe_gen #(
    .FLASH_CYCLES (FLASH_CYCLES)
  ) i_strobe_gen (
    .clk   (clk),
    .reset (reset),
    .flash (flash)
  );

  bin_to_bcd i_bin_to_bcd (
    .binary (score),
    .digits (digits)
  );

  // text select and font lookup
  text_overlay i_text_overlay (
    .clk    (clk),
    .reset  (reset),
    .mode   (mode),
    .sx     (sx),
    .sy     (sy),
    .flash  (flash),
    .digits (digits),
    .glyph  (glyph_bus.overlay),
    .r      (r),
    .g      (g),
    .b      (b)
  );

  font_rom i_font_rom (
    .glyph (glyph_bus.rom)
  );

endmodule : text_overlay_top

//--- verilog.f
game_pkg.sv
video_pkg.sv
glyph_if.sv
game_regs.sv
strobe_gen.sv
bin_to_bcd.sv
font_rom.sv
text_overlay.sv
text_overlay_top.sv
text_overlay_props.sv
tb_text_overlay.sv

//--- video_pkg.sv
package video_pkg;

  // screen is 256 columns by 512 rows
  typedef logic [7:0] coord_x_t;
  typedef logic [8:0] coord_y_t;

  // 4 bit grey level per colour channel
  typedef logic [3:0] color_t;

  // ascii character code
  typedef logic [7:0] char_code_t;

  // row or column inside one glyph
  typedef logic [2:0] glyph_idx_t;

  // glyph cell geometry in pixels
  localparam int CHAR_WIDTH = 8;
  localparam int CHAR_HEIGHT = 8;

endpackage : video_pkg
